// File: flist.f
src/mips_isa_pkg.sv
src/mips_pipe_pkg.sv
src/pipe_if.sv
src/apb_instr_port.sv
src/mips_decode.sv
src/mips_execute.sv
src/execute_memory_register.sv
src/mips_result.sv
src/mips_core_top.sv
tb/tb_clock_gen.sv
tb/tb_mips_core.sv

// File: tb/tb_mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;

	localparam int SAMPLE_DELAY = 1; // Outputs are read this long after the falling edge
	localparam int CYCLES_PER_ROW = 40;

	typedef struct packed {
		logic write;
		mips_pipe_pkg::apb_addr_t addr;
		mips_isa_pkg::word_t data;
		mips_isa_pkg::word_t exp_data;
		logic exp_err;
	} row_t;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	mips_pipe_pkg::apb_addr_t paddr;
	mips_isa_pkg::word_t pwdata;
	mips_isa_pkg::word_t prdata;
	logic pready;
	logic pslverr;
	row_t rows[$];
	logic table_ready = 1'b0;

	tb_clock_gen #(
		.PERIOD_NS(4),
		.RESET_CYCLES(2)
	) i_tb_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	mips_core_top #(
		.DMEM_DEPTH(64)
	) i_mips_core_top (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	function automatic mips_isa_pkg::word_t r_type(input mips_isa_pkg::reg_idx_t rs, rt, rd,
		input mips_isa_pkg::funct_t funct);
		return {mips_isa_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic mips_isa_pkg::word_t i_type(input mips_isa_pkg::opcode_t op,
		input mips_isa_pkg::reg_idx_t rs, rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_isa_pkg::word_t j_type(input mips_isa_pkg::opcode_t op,
		input logic [25:0] target);
		return {op, target};
	endfunction

	function automatic mips_pipe_pkg::apb_addr_t reg_addr(input mips_isa_pkg::reg_idx_t n);
		return mips_pipe_pkg::addr_gpr_base + {5'd0, n, 2'b00};
	endfunction

	task automatic issue_instr(input mips_isa_pkg::word_t word);
		rows.push_back({1'b1, mips_pipe_pkg::addr_instr, word, 32'h0, 1'b0});
	endtask

	task automatic expect_read(input mips_pipe_pkg::apb_addr_t addr,
		input mips_isa_pkg::word_t value);
		rows.push_back({1'b0, addr, 32'h0, value, 1'b0});
	endtask

	task automatic reject_access(input logic write, input mips_pipe_pkg::apb_addr_t addr,
		input mips_isa_pkg::word_t data);
		rows.push_back({write, addr, data, 32'h0, 1'b1});
	endtask

	task automatic build_table();
		for (int i = 0; i < 32; i++) begin
			expect_read(reg_addr(i[4:0]), 32'h0);
		end
		expect_read(mips_pipe_pkg::addr_hi, 32'h0);
		expect_read(mips_pipe_pkg::addr_lo, 32'h0);

		// Each result feeds the next instruction, so the write-back bypass is in use
		issue_instr(i_type(mips_isa_pkg::op_addi, 5'd0, 5'd1, 16'h0005)); // $1 = 5
		issue_instr(i_type(mips_isa_pkg::op_addi, 5'd1, 5'd2, 16'hfffd)); // $2 = 5 - 3
		issue_instr(r_type(5'd2, 5'd1, 5'd3, mips_isa_pkg::fn_add)); // $3 = 2 + 5
		issue_instr(r_type(5'd3, 5'd1, 5'd4, mips_isa_pkg::fn_sub)); // $4 = 7 - 5
		issue_instr(r_type(5'd0, 5'd4, 5'd5, mips_isa_pkg::fn_sub)); // $5 = -2
		issue_instr(r_type(5'd5, 5'd3, 5'd6, mips_isa_pkg::fn_and)); // $6 = 0xfffffffe & 7
		issue_instr(r_type(5'd6, 5'd1, 5'd7, mips_isa_pkg::fn_or)); // $7 = 6 | 5
		issue_instr(r_type(5'd5, 5'd7, 5'd8, mips_isa_pkg::fn_slt)); // Signed -2 < 7
		issue_instr(r_type(5'd7, 5'd5, 5'd9, mips_isa_pkg::fn_slt));
		issue_instr(i_type(mips_isa_pkg::op_addi, 5'd0, 5'd10, 16'h7ff0));
		issue_instr(i_type(mips_isa_pkg::op_addi, 5'd10, 5'd11, 16'h8000)); // 0x7ff0 - 0x8000
		expect_read(reg_addr(5'd1), 32'h0000_0005);
		expect_read(reg_addr(5'd2), 32'h0000_0002);
		expect_read(reg_addr(5'd3), 32'h0000_0007);
		expect_read(reg_addr(5'd4), 32'h0000_0002);
		expect_read(reg_addr(5'd5), 32'hffff_fffe);
		expect_read(reg_addr(5'd6), 32'h0000_0006);
		expect_read(reg_addr(5'd7), 32'h0000_0007);
		expect_read(reg_addr(5'd8), 32'h0000_0001);
		expect_read(reg_addr(5'd9), 32'h0000_0000);
		expect_read(reg_addr(5'd10), 32'h0000_7ff0);
		expect_read(reg_addr(5'd11), 32'hffff_fff0);

		issue_instr(i_type(mips_isa_pkg::op_addi, 5'd0, 5'd12, 16'h0010)); // Base address 16
		issue_instr(i_type(mips_isa_pkg::op_sw, 5'd12, 5'd5, 16'h0004)); // Word 5 = -2
		issue_instr(i_type(mips_isa_pkg::op_lw, 5'd12, 5'd13, 16'h0004));
		issue_instr(r_type(5'd13, 5'd1, 5'd14, mips_isa_pkg::fn_add)); // Uses the loaded word
		issue_instr(i_type(mips_isa_pkg::op_sw, 5'd12, 5'd10, 16'h0008)); // Word 6 = 0x7ff0
		issue_instr(i_type(mips_isa_pkg::op_lw, 5'd12, 5'd15, 16'h0008));
		expect_read(reg_addr(5'd13), 32'hffff_fffe);
		expect_read(reg_addr(5'd14), 32'h0000_0003);
		expect_read(reg_addr(5'd15), 32'h0000_7ff0);

		issue_instr(i_type(mips_isa_pkg::op_addi, 5'd0, 5'd16, 16'hfff9)); // $16 = -7
		issue_instr(i_type(mips_isa_pkg::op_addi, 5'd0, 5'd17, 16'h3000));
		issue_instr(r_type(5'd16, 5'd17, 5'd0, mips_isa_pkg::fn_mult)); // -7 * 12288 = -0x15000
		expect_read(mips_pipe_pkg::addr_hi, 32'hffff_ffff);
		expect_read(mips_pipe_pkg::addr_lo, 32'hfffe_b000);
		issue_instr(r_type(5'd0, 5'd0, 5'd18, mips_isa_pkg::fn_mfhi));
		issue_instr(r_type(5'd0, 5'd0, 5'd19, mips_isa_pkg::fn_mflo));
		issue_instr(r_type(5'd16, 5'd17, 5'd0, mips_isa_pkg::fn_multu)); // (2^32 - 7) * 12288
		issue_instr(r_type(5'd0, 5'd0, 5'd20, mips_isa_pkg::fn_mfhi)); // HI comes from bypass
		issue_instr(r_type(5'd16, 5'd5, 5'd0, mips_isa_pkg::fn_mult)); // -7 * -2
		issue_instr(r_type(5'd0, 5'd0, 5'd21, mips_isa_pkg::fn_mflo));
		expect_read(reg_addr(5'd18), 32'hffff_ffff);
		expect_read(reg_addr(5'd19), 32'hfffe_b000);
		expect_read(reg_addr(5'd20), 32'h0000_2fff);
		expect_read(reg_addr(5'd21), 32'h0000_000e);
		expect_read(mips_pipe_pkg::addr_hi, 32'h0000_0000);
		expect_read(mips_pipe_pkg::addr_lo, 32'h0000_000e);

		// Link values are the issue count times four plus four, 26 instructions so far
		issue_instr(j_type(mips_isa_pkg::op_jal, 26'h000_0040)); // $31 = 26 * 4 + 4
		issue_instr(r_type(5'd31, 5'd0, 5'd22, mips_isa_pkg::fn_jalr)); // $22 = 27 * 4 + 4
		issue_instr(j_type(mips_isa_pkg::op_j, 26'h39_0100)); // Fields name $1 and $25
		issue_instr(r_type(5'd1, 5'd0, 5'd23, mips_isa_pkg::fn_jr)); // Field names $23
		reject_access(1'b1, mips_pipe_pkg::addr_hi, 32'h1234_5678); // Not issued, not counted
		issue_instr(r_type(5'd1, 5'd0, 5'd24, mips_isa_pkg::fn_jalr)); // $24 = 30 * 4 + 4
		expect_read(reg_addr(5'd31), 32'h0000_006c);
		expect_read(reg_addr(5'd22), 32'h0000_0070);
		expect_read(reg_addr(5'd24), 32'h0000_007c);
		expect_read(reg_addr(5'd23), 32'h0000_0000);
		expect_read(reg_addr(5'd25), 32'h0000_0000);
		expect_read(reg_addr(5'd1), 32'h0000_0005);
		expect_read(reg_addr(5'd0), 32'h0000_0000);
		expect_read(mips_pipe_pkg::addr_hi, 32'h0000_0000);

		issue_instr(j_type(mips_isa_pkg::op_halt, 26'h0));
		reject_access(1'b1, mips_pipe_pkg::addr_instr,
			i_type(mips_isa_pkg::op_addi, 5'd0, 5'd1, 16'h0055));
		expect_read(reg_addr(5'd1), 32'h0000_0005);
		reject_access(1'b0, 12'h200, 32'h0);
		reject_access(1'b0, 12'h102, 32'h0); // Misaligned register address
		reject_access(1'b0, mips_pipe_pkg::addr_instr, 32'h0);
		expect_read(mips_pipe_pkg::addr_lo, 32'h0000_000e);
	endtask

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input int row,
		input mips_isa_pkg::word_t got, input mips_isa_pkg::word_t exp);
		assert (got === exp) else begin
			stop_with_failure($sformatf("Error %s at row %0d: expected %h, got %h",
				name, row, exp, got));
		end
	endtask

	// One APB transfer, entered and left on a falling edge
	task automatic apb_transfer(input logic write, input mips_pipe_pkg::apb_addr_t addr,
		input mips_isa_pkg::word_t wdata, output mips_isa_pkg::word_t rdata, output logic err,
		output int waits);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		waits = 0;
		@(negedge clk);
		penable = 1'b1;
		#SAMPLE_DELAY;
		while (pready !== 1'b1) begin
			waits++;
			@(negedge clk);
			#SAMPLE_DELAY;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk); // The rising edge in between completed the access
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	initial begin
		mips_isa_pkg::word_t rdata;
		logic err;
		int waits;
		logic prev_issue;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		prev_issue = 1'b0;
		build_table();
		table_ready = 1'b1;
		wait (reset === 1'b0);
		@(negedge clk);
		foreach (rows[i]) begin
			apb_transfer(rows[i].write, rows[i].addr, rows[i].data, rdata, err, waits);
			compare_word("pslverr", i, {31'd0, err}, {31'd0, rows[i].exp_err});
			// A read right behind an issued instruction waits while it sits in the memory stage
			compare_word("pready wait cycles", i, waits,
				(!rows[i].write && prev_issue) ? 32'd1 : 32'd0);
			if (!rows[i].write && !rows[i].exp_err)
				compare_word("prdata", i, rdata, rows[i].exp_data);
			prev_issue = rows[i].write && !rows[i].exp_err;
		end
		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		int limit;
		wait (table_ready === 1'b1);
		limit = rows.size() * CYCLES_PER_ROW + 10; // A little extra for the reset cycles
		repeat (limit) @(posedge clk);
		stop_with_failure($sformatf("Timeout: the APB sequence did not end within %0d cycles",
			limit));
	end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk); // Release on a falling edge, away from the DUT's sampling edge
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: src/mips_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core_top #(
	parameter int DMEM_DEPTH = 64
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input mips_pipe_pkg::apb_addr_t paddr,
	input mips_isa_pkg::word_t pwdata,
	output mips_isa_pkg::word_t prdata,
	output logic pready,
	output logic pslverr
);

	logic pipe_busy;
	logic halted;
	logic halt_seen;
	logic issue;
	mips_isa_pkg::word_t issue_word;
	mips_pipe_pkg::apb_addr_t rd_sel;
	mips_isa_pkg::word_t rd_data;

	dec_exec_if dx (.clk(clk));
	exec_mem_if em ();

	assign pipe_busy = dx.valid | em.mem_valid;
	// A halt still in flight already blocks the next instruction write
	assign halt_seen = halted | (dx.valid & dx.halt) | (em.mem_valid & em.mem_halt);

	apb_instr_port i_apb_instr_port (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pipe_busy(pipe_busy),
		.halted(halt_seen),
		.rd_data(rd_data),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.issue(issue),
		.issue_word(issue_word),
		.rd_sel(rd_sel)
	);

	mips_decode i_mips_decode (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.issue_word(issue_word),
		.rd_sel(rd_sel),
		.wb(em),
		.dx(dx),
		.rd_data(rd_data)
	);

	mips_execute i_mips_execute (
		.dx(dx),
		.ex(em)
	);

	execute_memory_register i_execute_memory_register (
		.clk(clk),
		.reset(reset),
		.ex(em),
		.mem(em)
	);

	mips_result #(
		.DMEM_DEPTH(DMEM_DEPTH)
	) i_mips_result (
		.clk(clk),
		.reset(reset),
		.mem(em),
		.wb(em),
		.halted(halted)
	);

endmodule

`default_nettype wire

// File: src/mips_result.sv
`timescale 1ns/100ps
`default_nettype none

module mips_result #(
	parameter int DMEM_DEPTH = 64
) (
	input logic clk,
	input logic reset,
	exec_mem_if.memory mem,
	exec_mem_if.wb_out wb,
	output logic halted
);

	localparam int AW = $clog2(DMEM_DEPTH);

	mips_isa_pkg::word_t dmem [DMEM_DEPTH];
	mips_isa_pkg::word_t gpr [32];
	mips_isa_pkg::word_t hi;
	mips_isa_pkg::word_t lo;
	logic [AW-1:0] dmem_idx;
	mips_isa_pkg::word_t load_data;

	assign dmem_idx = mem.mem_alu_result[AW+1:2]; // Word address
	assign load_data = dmem[dmem_idx];

	// Register 0 is never written, so it stays at its reset value of zero
	assign wb.wb_valid = mem.mem_valid & mem.mem_register_write & (mem.mem_write_register != '0);
	assign wb.wb_register = mem.mem_write_register;
	assign wb.wb_data = mem.mem_memory_to_register ? load_data : mem.mem_alu_result;
	assign wb.wb_hi_valid = mem.mem_valid & mem.mem_hi_write;
	assign wb.wb_hi = mem.mem_hi_result;
	assign wb.wb_lo_valid = mem.mem_valid & mem.mem_lo_write;
	assign wb.wb_lo = mem.mem_lo_result;

	assign wb.rf_a = gpr[wb.rf_idx_a];
	assign wb.rf_b = gpr[wb.rf_idx_b];
	assign wb.rf_c = gpr[wb.rf_idx_c];
	assign wb.hi_value = hi;
	assign wb.lo_value = lo;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				gpr[i] <= '0;
			end
			hi <= '0;
			lo <= '0;
			halted <= 1'b0;
		end else begin
			if (wb.wb_valid)
				gpr[wb.wb_register] <= wb.wb_data;
			if (wb.wb_hi_valid)
				hi <= wb.wb_hi;
			if (wb.wb_lo_valid)
				lo <= wb.wb_lo;
			if (mem.mem_valid && mem.mem_halt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mem.mem_valid && mem.mem_memory_write)
			dmem[dmem_idx] <= mem.mem_write_data;
	end

	assert property (@(posedge clk) disable iff (reset)
		mem.mem_valid && (mem.mem_memory_write || mem.mem_memory_to_register) |->
			mem.mem_alu_result[1:0] == 2'b00 && mem.mem_alu_result[31:2] < DMEM_DEPTH);

endmodule

`default_nettype wire

// File: src/execute_memory_register.sv
`timescale 1ns/100ps
`default_nettype none

module execute_memory_register (
	input logic clk,
	input logic reset,
	exec_mem_if.source ex,
	exec_mem_if.stage mem
);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			mem.mem_valid <= 1'b0;
			mem.mem_register_write <= 1'b0;
			mem.mem_memory_to_register <= 1'b0;
			mem.mem_memory_write <= 1'b0;
			mem.mem_hi_write <= 1'b0;
			mem.mem_lo_write <= 1'b0;
			mem.mem_jump <= 1'b0;
			mem.mem_jalr <= 1'b0;
			mem.mem_halt <= 1'b0;
			mem.mem_op <= '0;
			mem.mem_src_a <= '0;
			mem.mem_alu_result <= '0;
			mem.mem_hi_result <= '0;
			mem.mem_lo_result <= '0;
			mem.mem_write_data <= '0;
			mem.mem_write_register <= '0;
			mem.mem_jump_target <= '0;
		end else begin
			mem.mem_valid <= ex.ex_valid;
			mem.mem_register_write <= ex.ex_register_write;
			mem.mem_memory_to_register <= ex.ex_memory_to_register;
			mem.mem_memory_write <= ex.ex_memory_write;
			mem.mem_hi_write <= ex.ex_hi_write;
			mem.mem_lo_write <= ex.ex_lo_write;
			mem.mem_jump <= ex.ex_jump;
			mem.mem_jalr <= ex.ex_jalr;
			mem.mem_halt <= ex.ex_halt;
			mem.mem_op <= ex.ex_op;
			mem.mem_src_a <= ex.ex_src_a;
			mem.mem_alu_result <= ex.ex_alu_result;
			mem.mem_hi_result <= ex.ex_hi_result;
			mem.mem_lo_result <= ex.ex_lo_result;
			mem.mem_write_data <= ex.ex_write_data;
			mem.mem_write_register <= ex.ex_write_register;
			mem.mem_jump_target <= ex.ex_jump_target;
		end
	end

endmodule

`default_nettype wire

// File: src/mips_execute.sv
`timescale 1ns/100ps
`default_nettype none

module mips_execute (
	dec_exec_if.execute dx,
	exec_mem_if.execute ex
);

	logic [65:0] product;
	mips_isa_pkg::word_t link;

	assign link = dx.issue_addr + 32'd4;

	// One extra bit per operand lets a single signed multiplier serve multu as well
	assign product = $signed({dx.signed_mult & dx.op_a[31], dx.op_a}) *
		$signed({dx.signed_mult & dx.op_b[31], dx.op_b});

	always_comb begin
		case (dx.alu_op)
			mips_pipe_pkg::alu_sub: ex.ex_alu_result = dx.op_a - dx.src_b;
			mips_pipe_pkg::alu_and: ex.ex_alu_result = dx.op_a & dx.src_b;
			mips_pipe_pkg::alu_or: ex.ex_alu_result = dx.op_a | dx.src_b;
			mips_pipe_pkg::alu_slt: ex.ex_alu_result = {31'd0, $signed(dx.op_a) < $signed(dx.src_b)};
			mips_pipe_pkg::alu_pass_a: ex.ex_alu_result = dx.op_a;
			mips_pipe_pkg::alu_pass_b: ex.ex_alu_result = dx.src_b;
			mips_pipe_pkg::alu_link: ex.ex_alu_result = link;
			default: ex.ex_alu_result = dx.op_a + dx.src_b;
		endcase
	end

	assign ex.ex_hi_result = product[63:32];
	assign ex.ex_lo_result = product[31:0];
	assign ex.ex_jump_target = dx.jalr ? dx.op_a : {link[31:28], dx.jump_field, 2'b00};

	assign ex.ex_valid = dx.valid;
	assign ex.ex_register_write = dx.register_write;
	assign ex.ex_memory_to_register = dx.memory_to_register;
	assign ex.ex_memory_write = dx.memory_write;
	assign ex.ex_hi_write = dx.hi_write;
	assign ex.ex_lo_write = dx.lo_write;
	assign ex.ex_jump = dx.jump;
	assign ex.ex_jalr = dx.jalr;
	assign ex.ex_halt = dx.halt;
	assign ex.ex_op = dx.op;
	assign ex.ex_src_a = dx.op_a;
	assign ex.ex_write_data = dx.store_data;
	assign ex.ex_write_register = dx.write_register;

	assert property (@(posedge dx.clk) dx.valid |-> dx.hi_write == dx.lo_write);

endmodule

`default_nettype wire

// File: src/mips_decode.sv
`timescale 1ns/100ps
`default_nettype none

module mips_decode (
	input logic clk,
	input logic reset,
	input logic issue,
	input mips_isa_pkg::word_t issue_word,
	input mips_pipe_pkg::apb_addr_t rd_sel,
	exec_mem_if.wb_in wb,
	dec_exec_if.decode dx,
	output mips_isa_pkg::word_t rd_data
);

	mips_isa_pkg::opcode_t op;
	mips_isa_pkg::funct_t funct;
	mips_isa_pkg::reg_idx_t rs;
	mips_isa_pkg::reg_idx_t rt;
	mips_isa_pkg::reg_idx_t rd;
	mips_isa_pkg::reg_idx_t wr;
	mips_isa_pkg::word_t imm;
	mips_isa_pkg::word_t a_val;
	mips_isa_pkg::word_t b_val;
	mips_isa_pkg::word_t hi_val;
	mips_isa_pkg::word_t lo_val;
	mips_isa_pkg::word_t issue_count;
	mips_pipe_pkg::alu_op_t alu_op;
	logic is_r;
	logic use_imm;
	logic rw;
	logic mult;
	logic jalr;
	logic jump;

	function automatic mips_isa_pkg::word_t bypass(input mips_isa_pkg::reg_idx_t idx,
		input mips_isa_pkg::word_t rf);
		return (wb.wb_valid && wb.wb_register == idx) ? wb.wb_data : rf;
	endfunction

	assign op = issue_word[31:26];
	assign rs = issue_word[25:21];
	assign rt = issue_word[20:16];
	assign rd = issue_word[15:11];
	assign funct = issue_word[5:0];
	assign imm = {{16{issue_word[15]}}, issue_word[15:0]};

	assign wb.rf_idx_a = rs;
	assign wb.rf_idx_b = rt;
	assign wb.rf_idx_c = rd_sel[6:2];
	assign a_val = bypass(rs, wb.rf_a);
	assign b_val = bypass(rt, wb.rf_b);
	assign hi_val = wb.wb_hi_valid ? wb.wb_hi : wb.hi_value;
	assign lo_val = wb.wb_lo_valid ? wb.wb_lo : wb.lo_value;

	assign is_r = op == mips_isa_pkg::op_rtype;
	assign use_imm = op inside {mips_isa_pkg::op_addi, mips_isa_pkg::op_lw, mips_isa_pkg::op_sw};
	assign mult = is_r && funct inside {mips_isa_pkg::fn_mult, mips_isa_pkg::fn_multu};
	assign jalr = is_r && funct inside {mips_isa_pkg::fn_jr, mips_isa_pkg::fn_jalr};
	assign jump = jalr || op == mips_isa_pkg::op_j || op == mips_isa_pkg::op_jal;
	assign rw = is_r ? funct inside {mips_isa_pkg::fn_add, mips_isa_pkg::fn_sub,
		mips_isa_pkg::fn_and, mips_isa_pkg::fn_or, mips_isa_pkg::fn_slt, mips_isa_pkg::fn_mfhi,
		mips_isa_pkg::fn_mflo, mips_isa_pkg::fn_jalr} :
		op inside {mips_isa_pkg::op_addi, mips_isa_pkg::op_lw, mips_isa_pkg::op_jal};
	assign wr = is_r ? rd : (op == mips_isa_pkg::op_jal ? 5'd31 : rt);

	always_comb begin
		alu_op = mips_pipe_pkg::alu_add;
		if (op == mips_isa_pkg::op_jal) begin
			alu_op = mips_pipe_pkg::alu_link;
		end else if (is_r) begin
			case (funct)
				mips_isa_pkg::fn_sub: alu_op = mips_pipe_pkg::alu_sub;
				mips_isa_pkg::fn_and: alu_op = mips_pipe_pkg::alu_and;
				mips_isa_pkg::fn_or: alu_op = mips_pipe_pkg::alu_or;
				mips_isa_pkg::fn_slt: alu_op = mips_pipe_pkg::alu_slt;
				mips_isa_pkg::fn_mfhi: alu_op = mips_pipe_pkg::alu_pass_a;
				mips_isa_pkg::fn_mflo: alu_op = mips_pipe_pkg::alu_pass_b;
				mips_isa_pkg::fn_jalr: alu_op = mips_pipe_pkg::alu_link;
				default: alu_op = mips_pipe_pkg::alu_add;
			endcase
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			dx.valid <= 1'b0;
			dx.register_write <= 1'b0;
			dx.memory_to_register <= 1'b0;
			dx.memory_write <= 1'b0;
			dx.hi_write <= 1'b0;
			dx.lo_write <= 1'b0;
			dx.jump <= 1'b0;
			dx.jalr <= 1'b0;
			dx.halt <= 1'b0;
			issue_count <= '0;
		end else begin
			dx.valid <= issue;
			dx.register_write <= issue & rw;
			dx.memory_to_register <= issue & (op == mips_isa_pkg::op_lw);
			dx.memory_write <= issue & (op == mips_isa_pkg::op_sw);
			dx.hi_write <= issue & mult; // mult and multu always write both halves
			dx.lo_write <= issue & mult;
			dx.jump <= issue & jump;
			dx.jalr <= issue & jalr;
			dx.halt <= issue & (op == mips_isa_pkg::op_halt);
			if (issue)
				issue_count <= issue_count + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		dx.alu_op <= alu_op;
		dx.op_a <= (is_r && funct == mips_isa_pkg::fn_mfhi) ? hi_val : a_val;
		dx.op_b <= b_val;
		dx.src_b <= use_imm ? imm : ((is_r && funct == mips_isa_pkg::fn_mflo) ? lo_val : b_val);
		dx.signed_mult <= funct == mips_isa_pkg::fn_mult;
		dx.op <= op;
		dx.write_register <= wr;
		dx.store_data <= b_val;
		dx.jump_field <= issue_word[25:0];
		dx.issue_addr <= {issue_count[29:0], 2'b00};
	end

	always_comb begin
		case (rd_sel)
			mips_pipe_pkg::addr_hi: rd_data = hi_val;
			mips_pipe_pkg::addr_lo: rd_data = lo_val;
			default: rd_data = bypass(rd_sel[6:2], wb.rf_c);
		endcase
	end

endmodule

`default_nettype wire

// File: src/apb_instr_port.sv
`timescale 1ns/100ps
`default_nettype none

module apb_instr_port (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input mips_pipe_pkg::apb_addr_t paddr,
	input mips_isa_pkg::word_t pwdata,
	input logic pipe_busy,
	input logic halted,
	input mips_isa_pkg::word_t rd_data,
	output mips_isa_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	output logic issue,
	output mips_isa_pkg::word_t issue_word,
	output mips_pipe_pkg::apb_addr_t rd_sel
);

	mips_pipe_pkg::apb_state_t state;
	logic access;
	logic rd_access;
	logic addr_ok;

	assign access = psel & penable;
	assign rd_access = access & !pwrite;

	// Writes only go to the instruction port, reads to GPRs, HI or LO
	assign addr_ok = pwrite ? (paddr == mips_pipe_pkg::addr_instr && !halted) :
		(paddr[11:7] == mips_pipe_pkg::addr_gpr_base[11:7] && paddr[1:0] == 2'b00) ||
		paddr == mips_pipe_pkg::addr_hi || paddr == mips_pipe_pkg::addr_lo;

	assign pready = (state == mips_pipe_pkg::apb_idle) ? !(rd_access & pipe_busy) : !pipe_busy;
	assign pslverr = access & pready & !addr_ok;
	assign issue = access & pwrite & addr_ok;
	assign issue_word = pwdata;
	assign rd_sel = paddr;
	assign prdata = rd_data; // Decode already applies the write-back bypass

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= mips_pipe_pkg::apb_idle;
		end else begin
			case (state)
				mips_pipe_pkg::apb_idle: if (rd_access && pipe_busy) state <= mips_pipe_pkg::apb_wait_drain;
				mips_pipe_pkg::apb_wait_drain: if (!pipe_busy) state <= mips_pipe_pkg::apb_idle;
				default: state <= mips_pipe_pkg::apb_idle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) penable |-> psel);

endmodule

`default_nettype wire

// File: src/pipe_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dec_exec_if (input logic clk);
	logic valid;
	mips_pipe_pkg::alu_op_t alu_op;
	mips_isa_pkg::word_t op_a;
	mips_isa_pkg::word_t op_b;
	mips_isa_pkg::word_t src_b; // Immediate or register operand, as the ALU sees it
	logic register_write;
	logic memory_to_register;
	logic memory_write;
	logic hi_write;
	logic lo_write;
	logic signed_mult;
	logic jump;
	logic jalr;
	logic halt;
	mips_isa_pkg::opcode_t op;
	mips_isa_pkg::reg_idx_t write_register;
	mips_isa_pkg::word_t store_data;
	logic [25:0] jump_field;
	mips_isa_pkg::word_t issue_addr;

	modport decode (output valid, alu_op, op_a, op_b, src_b, register_write,
		memory_to_register, memory_write, hi_write, lo_write, signed_mult, jump, jalr,
		halt, op, write_register, store_data, jump_field, issue_addr);
	modport execute (input clk, valid, alu_op, op_a, op_b, src_b, register_write,
		memory_to_register, memory_write, hi_write, lo_write, signed_mult, jump, jalr,
		halt, op, write_register, store_data, jump_field, issue_addr);
endinterface

interface exec_mem_if;
	logic ex_valid, mem_valid;
	logic ex_register_write, mem_register_write;
	logic ex_memory_to_register, mem_memory_to_register;
	logic ex_memory_write, mem_memory_write;
	logic ex_hi_write, mem_hi_write;
	logic ex_lo_write, mem_lo_write;
	logic ex_jump, mem_jump;
	logic ex_jalr, mem_jalr;
	logic ex_halt, mem_halt;
	mips_isa_pkg::opcode_t ex_op, mem_op;
	mips_isa_pkg::word_t ex_src_a, mem_src_a;
	mips_isa_pkg::word_t ex_alu_result, mem_alu_result;
	mips_isa_pkg::word_t ex_hi_result, mem_hi_result;
	mips_isa_pkg::word_t ex_lo_result, mem_lo_result;
	mips_isa_pkg::word_t ex_write_data, mem_write_data;
	mips_isa_pkg::reg_idx_t ex_write_register, mem_write_register;
	mips_isa_pkg::word_t ex_jump_target, mem_jump_target;

	// Write-back port, with the register file read ports riding along
	logic wb_valid;
	mips_isa_pkg::reg_idx_t wb_register;
	mips_isa_pkg::word_t wb_data;
	logic wb_hi_valid;
	mips_isa_pkg::word_t wb_hi;
	logic wb_lo_valid;
	mips_isa_pkg::word_t wb_lo;
	mips_isa_pkg::reg_idx_t rf_idx_a, rf_idx_b, rf_idx_c;
	mips_isa_pkg::word_t rf_a, rf_b, rf_c;
	mips_isa_pkg::word_t hi_value, lo_value;

	modport execute (output ex_valid, ex_register_write, ex_memory_to_register,
		ex_memory_write, ex_hi_write, ex_lo_write, ex_jump, ex_jalr, ex_halt, ex_op,
		ex_src_a, ex_alu_result, ex_hi_result, ex_lo_result, ex_write_data,
		ex_write_register, ex_jump_target);
	modport source (input ex_valid, ex_register_write, ex_memory_to_register,
		ex_memory_write, ex_hi_write, ex_lo_write, ex_jump, ex_jalr, ex_halt, ex_op,
		ex_src_a, ex_alu_result, ex_hi_result, ex_lo_result, ex_write_data,
		ex_write_register, ex_jump_target);
	modport stage (output mem_valid, mem_register_write, mem_memory_to_register,
		mem_memory_write, mem_hi_write, mem_lo_write, mem_jump, mem_jalr, mem_halt, mem_op,
		mem_src_a, mem_alu_result, mem_hi_result, mem_lo_result, mem_write_data,
		mem_write_register, mem_jump_target);
	modport memory (input mem_valid, mem_register_write, mem_memory_to_register,
		mem_memory_write, mem_hi_write, mem_lo_write, mem_jump, mem_jalr, mem_halt, mem_op,
		mem_src_a, mem_alu_result, mem_hi_result, mem_lo_result, mem_write_data,
		mem_write_register, mem_jump_target);
	modport wb_out (output wb_valid, wb_register, wb_data, wb_hi_valid, wb_hi, wb_lo_valid,
		wb_lo, rf_a, rf_b, rf_c, hi_value, lo_value, input rf_idx_a, rf_idx_b, rf_idx_c);
	modport wb_in (input wb_valid, wb_register, wb_data, wb_hi_valid, wb_hi, wb_lo_valid,
		wb_lo, rf_a, rf_b, rf_c, hi_value, lo_value, output rf_idx_a, rf_idx_b, rf_idx_c);
endinterface

`default_nettype wire

// File: src/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_pass_a,
		alu_pass_b,
		alu_link
	} alu_op_t;

	typedef logic [11:0] apb_addr_t;

	localparam apb_addr_t addr_instr = 12'h000;
	localparam apb_addr_t addr_gpr_base = 12'h100; // 32 words up to 0x17c
	localparam apb_addr_t addr_hi = 12'h180;
	localparam apb_addr_t addr_lo = 12'h184;

	typedef enum logic {
		apb_idle,
		apb_wait_drain
	} apb_state_t;

endpackage

`default_nettype wire

// File: src/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	localparam opcode_t op_rtype = 6'h00;
	localparam opcode_t op_addi = 6'h08;
	localparam opcode_t op_lw = 6'h23;
	localparam opcode_t op_sw = 6'h2b;
	localparam opcode_t op_j = 6'h02;
	localparam opcode_t op_jal = 6'h03;
	localparam opcode_t op_halt = 6'h3f; // Not a MIPS opcode, stops the core

	localparam funct_t fn_add = 6'h20;
	localparam funct_t fn_sub = 6'h22;
	localparam funct_t fn_and = 6'h24;
	localparam funct_t fn_or = 6'h25;
	localparam funct_t fn_slt = 6'h2a;
	localparam funct_t fn_mult = 6'h18;
	localparam funct_t fn_multu = 6'h19;
	localparam funct_t fn_mfhi = 6'h10;
	localparam funct_t fn_mflo = 6'h12;
	localparam funct_t fn_jr = 6'h08;
	localparam funct_t fn_jalr = 6'h09;

endpackage

`default_nettype wire
